//--- tb/ddrstat_testdata.txt
# C repeat avalid.aready.atype wvalid.wready.wlast rvalid.rready.rlast TestErr StatiClr
# E ErrCnt OpTotCyc OpActCyc WrPeriMin WrPeriMax RdPeriMin RdPeriMax, all hex
C 2 000 000 000 0 0
C 1 111 000 000 0 0
C 1 101 100 000 0 0
C 2 110 110 000 1 0
C 1 000 111 000 0 0
C 1 000 000 111 0 0
C 1 111 000 110 0 0
C 1 000 110 110 0 0
C 1 000 110 100 1 0
C 1 000 111 110 0 0
C 2 000 000 110 0 0
C 1 111 000 111 0 0
C 4 000 110 000 0 0
C 4 000 100 000 0 0
C 1 000 111 000 1 0
C 1 111 110 000 0 0
C 1 000 110 000 1 0
C 1 000 111 000 1 0
C 1 110 000 000 0 0
C 6 000 000 110 0 0
C 1 000 000 111 0 0
E 6 1e 1c 3 c 7 14
C 1 000 000 000 0 1
E 0 0 0 3ff 0 3ff 0
# Long idle stretch, then traffic with a 150 cycle gap
C 300 000 000 000 0 0
C 1 110 000 000 0 0
C 1 000 000 111 1 0
C 1 111 000 000 0 0
C 1 000 111 000 0 0
C 150 000 000 000 0 0
C 1 111 000 000 1 0
C 1 110 111 000 1 0
C 1 000 000 111 0 0
E 3 4 4 98 98 9b 9b

//--- sim.f
source/DdrStatPkg.sv
source/AxiEventDecode.sv
source/BusOccupancy.sv
source/BurstPeriodStat.sv
source/IdleErrMonitor.sv
source/DdrTestStat.sv
tb/DdrTestStat_checker.sv
tb/DdrTestStatTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = DdrTestStatTb
FILELIST  = sim.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)
PASSMSG   = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIMBIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

//--- tb/DdrTestStatTb.sv
`timescale 1ns/1ps
`default_nettype none

module DdrTestStatTb;

  import DdrStatPkg::*;

  logic    SysClk, Reset_N;
  logic    avalid, aready, atype;               // Address channel
  logic    wvalid, wready, wlast;               // Write data channel
  logic    rvalid, rready, rlast;               // Read data channel
  logic    TestErr, StatiClr, TimeOut;
  ErrCnt_t ErrCnt;
  CycCnt_t OpTotCyc, OpActCyc;
  Period_t WrPeriMin, WrPeriMax, RdPeriMin, RdPeriMax;

  int ErrCount = 0;                             // DUT mismatches
  int FileErrs = 0;                             // Data file or model trouble
  int CycleTotal = 0;                           // Input cycles in the data file
  int ERecords = 0;                             // Expected records in the file
  int ERecNo = 0;
  int Limit = 0;                                // Watchdog cycle limit
  bit LimitReady = 1'b0;
  int DutPulses = 0;                            // TimeOut pulses seen

  // Reference model state, one step per input cycle
  ErrCnt_t MdlErr;
  CycCnt_t MdlTot, MdlAct;
  Period_t MdlWrMin, MdlWrMax, MdlRdMin, MdlRdMax;
  int      WrOut, RdOut, IdleLeft, MdlPulses, CycleIdx, WrLast, RdLast;
  bit      WrStarted, RdStarted;

  DdrTestStat dut0 (
    .SysClk    (SysClk),
    .Reset_N   (Reset_N),
    .avalid    (avalid),
    .aready    (aready),
    .atype     (atype),
    .wvalid    (wvalid),
    .wready    (wready),
    .wlast     (wlast),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .TestErr   (TestErr),
    .StatiClr  (StatiClr),
    .ErrCnt    (ErrCnt),
    .OpTotCyc  (OpTotCyc),
    .OpActCyc  (OpActCyc),
    .WrPeriMin (WrPeriMin),
    .WrPeriMax (WrPeriMax),
    .RdPeriMin (RdPeriMin),
    .RdPeriMax (RdPeriMax),
    .TimeOut   (TimeOut)
  );

  initial
  begin
    SysClk = 1'b0;
    forever #10 SysClk = ~SysClk;               // 20 ns period
  end

  always @(negedge SysClk)
  begin
    if (Reset_N && TimeOut)
      DutPulses++;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  task clearStats();
    MdlErr    = '0;
    MdlTot    = '0;
    MdlAct    = '0;
    MdlWrMin  = PeriodMinInit;
    MdlRdMin  = PeriodMinInit;
    MdlWrMax  = '0;
    MdlRdMax  = '0;
    WrStarted = 1'b0;                           // Next end starts a new gap
    RdStarted = 1'b0;
  endtask

  task recordEnd(inout int LastEnd, inout bit Started, inout Period_t PMin,
                 inout Period_t PMax);
    int Gap;
    Gap = CycleIdx - LastEnd;
    if (Gap > 1023)
      Gap = 1023;                               // Gap counter saturates
    if (Started)
    begin
      if (Period_t'(Gap) < PMin)
        PMin = Period_t'(Gap);
      if (Period_t'(Gap) > PMax)
        PMax = Period_t'(Gap);
    end
    LastEnd = CycleIdx;
    Started = 1'b1;
  endtask

  task applyModel();
    logic Wa, Ra, Wb, Rb, We, Re;
    Wa = avalid & aready & atype;               // Transfer needs valid and ready
    Ra = avalid & aready & ~atype;
    Wb = wvalid & wready;
    Rb = rvalid & rready;
    We = Wb & wlast;
    Re = Rb & rlast;
    if (IdleLeft == 1)
      MdlPulses++;                              // Pulse follows the cycle at 1
    if (Wa || Ra || Wb || Rb)
      IdleLeft = 255;
    else if (IdleLeft > 0)
      IdleLeft--;
    if (StatiClr)
      clearStats();
    if (Wa && !We && WrOut < 255)
      WrOut++;
    else if (We && !Wa && WrOut > 0)
      WrOut--;
    if (Ra && !Re && RdOut < 255)
      RdOut++;
    else if (Re && !Ra && RdOut > 0)
      RdOut--;
    if (WrOut != 0 || RdOut != 0)
      MdlTot = MdlTot + CycCnt_t'(1);           // Busy after this cycle's events
    MdlAct = MdlAct + CycCnt_t'(Wb) + CycCnt_t'(Rb);
    if (TestErr && MdlErr != '1)
      MdlErr = MdlErr + ErrCnt_t'(1);
    if (We)
      recordEnd(WrLast, WrStarted, MdlWrMin, MdlWrMax);
    if (Re)
      recordEnd(RdLast, RdStarted, MdlRdMin, MdlRdMax);
    CycleIdx++;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  // Called at a falling edge, returns at the next one
  task driveCycle(input logic [2:0] AGrp, input logic [2:0] WGrp, input logic [2:0] RGrp,
                  input logic ErrBit, input logic ClrBit);
    {avalid, aready, atype} = AGrp;
    {wvalid, wready, wlast} = WGrp;
    {rvalid, rready, rlast} = RGrp;
    TestErr  = ErrBit;
    StatiClr = ClrBit;
    applyModel();
    @(negedge SysClk);
  endtask

  task checkModel(input string Name, input CycCnt_t FileVal, input CycCnt_t MdlVal);
    if (FileVal != MdlVal)
    begin
      $display("Data file record %0d gives %s as %h but the model computes %h",
               ERecNo, Name, FileVal, MdlVal);
      FileErrs++;
    end
  endtask

  task compareField(input string Name, input CycCnt_t ExpVal, input CycCnt_t GotVal);
    if (GotVal !== ExpVal)
    begin
      $display("ERROR %s expected %h got %h", Name, ExpVal, GotVal);
      ErrCount++;
    end
  endtask

  // First pass only counts cycles, second pass drives and checks
  task readRecords(input bit Execute);
    int         Fd, C, Rep, Code;
    logic [7:0] Ch;
    logic [2:0] AGrp, WGrp, RGrp;
    logic       ErrBit, ClrBit;
    ErrCnt_t    EErr;
    CycCnt_t    ETot, EAct;
    Period_t    EWMin, EWMax, ERMin, ERMax;
    bit         Done;
    Done = 1'b0;
    Fd = $fopen("tb/ddrstat_testdata.txt", "r");
    if (Fd == 0)
    begin
      if (Execute)
      begin
        $display("Cannot open the test data file tb/ddrstat_testdata.txt");
        FileErrs++;
      end
      Done = 1'b1;
    end
    while (!Done)
    begin
      C = $fgetc(Fd);
      Ch = C[7:0];
      if (C < 0)
        Done = 1'b1;                            // End of file
      else if (Ch == "#")
      begin
        while (C >= 0 && C != 10)
          C = $fgetc(Fd);                       // Skip comment line
      end
      else if (Ch == "C")
      begin
        Code = $fscanf(Fd, "%d %b %b %b %b %b", Rep, AGrp, WGrp, RGrp, ErrBit, ClrBit);
        if (Code != 6)
        begin
          if (Execute)
          begin
            $display("Malformed cycle record in the test data file");
            FileErrs++;
          end
          Done = 1'b1;
        end
        else if (Execute)
          repeat (Rep) driveCycle(AGrp, WGrp, RGrp, ErrBit, ClrBit);
        else
          CycleTotal += Rep;
      end
      else if (Ch == "E")
      begin
        Code = $fscanf(Fd, "%h %h %h %h %h %h %h", EErr, ETot, EAct,
                       EWMin, EWMax, ERMin, ERMax);
        if (Code != 7)
        begin
          if (Execute)
          begin
            $display("Malformed expected record in the test data file");
            FileErrs++;
          end
          Done = 1'b1;
        end
        else if (!Execute)
          ERecords++;
        else
        begin
          repeat (8) driveCycle(3'b000, 3'b000, 3'b000, 1'b0, 1'b0); // Pipeline drain
          ERecNo++;
          checkModel("ErrCnt", CycCnt_t'(EErr), CycCnt_t'(MdlErr));
          checkModel("OpTotCyc", ETot, MdlTot);
          checkModel("OpActCyc", EAct, MdlAct);
          checkModel("WrPeriMin", CycCnt_t'(EWMin), CycCnt_t'(MdlWrMin));
          checkModel("WrPeriMax", CycCnt_t'(EWMax), CycCnt_t'(MdlWrMax));
          checkModel("RdPeriMin", CycCnt_t'(ERMin), CycCnt_t'(MdlRdMin));
          checkModel("RdPeriMax", CycCnt_t'(ERMax), CycCnt_t'(MdlRdMax));
          compareField("ErrCnt", CycCnt_t'(EErr), CycCnt_t'(ErrCnt));
          compareField("OpTotCyc", ETot, OpTotCyc);
          compareField("OpActCyc", EAct, OpActCyc);
          compareField("WrPeriMin", CycCnt_t'(EWMin), CycCnt_t'(WrPeriMin));
          compareField("WrPeriMax", CycCnt_t'(EWMax), CycCnt_t'(WrPeriMax));
          compareField("RdPeriMin", CycCnt_t'(ERMin), CycCnt_t'(RdPeriMin));
          compareField("RdPeriMax", CycCnt_t'(ERMax), CycCnt_t'(RdPeriMax));
        end
      end
      else if (Ch != " " && Ch != "\n" && Ch != "\r" && Ch != "\t")
      begin
        if (Execute)
        begin
          $display("Unknown record type in the test data file");
          FileErrs++;
        end
        Done = 1'b1;
      end
    end
    if (Fd != 0)
      $fclose(Fd);
  endtask

  initial
  begin
    Reset_N = 1'b0;
    {avalid, aready, atype} = 3'b000;
    {wvalid, wready, wlast} = 3'b000;
    {rvalid, rready, rlast} = 3'b000;
    TestErr  = 1'b0;
    StatiClr = 1'b0;
    clearStats();
    WrOut     = 0;
    RdOut     = 0;
    IdleLeft  = 255;                            // Idle counter reset value
    MdlPulses = 0;
    CycleIdx  = 0;
    WrLast    = 0;
    RdLast    = 0;
    readRecords(1'b0);
    Limit = CycleTotal + 8 * ERecords + 600;
    LimitReady = 1'b1;
    repeat (8) @(negedge SysClk);
    Reset_N = 1'b1;
    readRecords(1'b1);
    if (DutPulses != MdlPulses)
    begin
      $display("ERROR TimeOut pulse count expected %h got %h", MdlPulses, DutPulses);
      ErrCount++;
    end
    $display("Checks done, %0d DUT mismatches, %0d data file errors, %0d assertion failures",
             ErrCount, FileErrs, dut0.checker0.FailCount);
    if (ErrCount == 0 && FileErrs == 0 && dut0.checker0.FailCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    int Cycles;
    Cycles = 0;
    wait (LimitReady);
    while (Cycles < Limit)
    begin
      @(posedge SysClk);
      Cycles++;
    end
    $display("Run stopped after %0d cycles before the test data was finished", Cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/DdrTestStat_checker.sv
`timescale 1ns/1ps
`default_nettype none

module DdrStatChecker
(
  input wire logic                SysClk,
  input wire logic                Reset_N,
  input wire logic                StatiClr,
  input wire logic                TimeOut,
  input wire DdrStatPkg::ErrCnt_t ErrCnt,
  input wire DdrStatPkg::Period_t WrPeriMin,
  input wire DdrStatPkg::Period_t WrPeriMax,
  input wire DdrStatPkg::Period_t RdPeriMin,
  input wire DdrStatPkg::Period_t RdPeriMax
);

  int FailCount = 0;                            // Failed assertions so far

  // One-shot per idle stretch
  TimeOutSingle: assert property (@(posedge SysClk) disable iff (!Reset_N)
    TimeOut |=> !TimeOut)
  else
  begin
    $error("TimeOut high for two cycles running");
    FailCount++;
  end

  TimeOutReset: assert property (@(posedge SysClk) !Reset_N |-> !TimeOut)
  else
  begin
    $error("TimeOut high during reset");
    FailCount++;
  end

  // Only a clear may lower the count
  ErrCntRise: assert property (@(posedge SysClk) disable iff (!Reset_N)
    (ErrCnt < $past(ErrCnt)) |-> $past(StatiClr))
  else
  begin
    $error("ErrCnt decreased without clear");
    FailCount++;
  end

  WrOrder: assert property (@(posedge SysClk) disable iff (!Reset_N)
    (WrPeriMax != '0) |-> (WrPeriMin <= WrPeriMax))
  else
  begin
    $error("WrPeriMin above WrPeriMax");
    FailCount++;
  end

  RdOrder: assert property (@(posedge SysClk) disable iff (!Reset_N)
    (RdPeriMax != '0) |-> (RdPeriMin <= RdPeriMax))
  else
  begin
    $error("RdPeriMin above RdPeriMax");
    FailCount++;
  end

endmodule

bind DdrTestStat DdrStatChecker checker0 (.*);

`default_nettype wire

//--- source/DdrTestStat.sv
`timescale 1ns/1ps
`default_nettype none

module DdrTestStat
(
  input  wire logic           SysClk,     // System clock
  input  wire logic           Reset_N,    // Async reset, active low
  input  wire logic           avalid,     // Address valid
  input  wire logic           aready,     // Address ready
  input  wire logic           atype,      // Burst type, 1 write, 0 read
  input  wire logic           wvalid,     // Write data valid
  input  wire logic           wready,     // Write data ready
  input  wire logic           wlast,      // Last write beat
  input  wire logic           rvalid,     // Read data valid
  input  wire logic           rready,     // Read data ready
  input  wire logic           rlast,      // Last read beat
  input  wire logic           TestErr,    // Test engine data error
  input  wire logic           StatiClr,   // Statistics clear
  output DdrStatPkg::ErrCnt_t ErrCnt,     // Test error count
  output DdrStatPkg::CycCnt_t OpTotCyc,   // Busy cycles
  output DdrStatPkg::CycCnt_t OpActCyc,   // Data beat cycles
  output DdrStatPkg::Period_t WrPeriMin,  // Shortest write end gap
  output DdrStatPkg::Period_t WrPeriMax,  // Longest write end gap
  output DdrStatPkg::Period_t RdPeriMin,  // Shortest read end gap
  output DdrStatPkg::Period_t RdPeriMax,  // Longest read end gap
  output logic                TimeOut     // Bus idle timeout pulse
);

  logic WrAddrEvt, RdAddrEvt;                   // Burst starts
  logic WrBeatEvt, RdBeatEvt;                   // Data beats
  logic WrEndEvt, RdEndEvt;                     // Burst ends
  logic BusActive;                              // Any bus activity

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  AxiEventDecode decode0 (
    .SysClk    (SysClk),
    .Reset_N   (Reset_N),
    .avalid    (avalid),
    .aready    (aready),
    .atype     (atype),
    .wvalid    (wvalid),
    .wready    (wready),
    .wlast     (wlast),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .WrAddrEvt (WrAddrEvt),
    .RdAddrEvt (RdAddrEvt),
    .WrBeatEvt (WrBeatEvt),
    .RdBeatEvt (RdBeatEvt),
    .WrEndEvt  (WrEndEvt),
    .RdEndEvt  (RdEndEvt)
  );

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  BusOccupancy occupancy0 (
    .SysClk    (SysClk),
    .Reset_N   (Reset_N),
    .StatiClr  (StatiClr),
    .WrAddrEvt (WrAddrEvt),
    .RdAddrEvt (RdAddrEvt),
    .WrBeatEvt (WrBeatEvt),
    .RdBeatEvt (RdBeatEvt),
    .WrEndEvt  (WrEndEvt),
    .RdEndEvt  (RdEndEvt),
    .BusActive (BusActive),
    .OpTotCyc  (OpTotCyc),
    .OpActCyc  (OpActCyc)
  );

  ////////////////////////////////////////////////////////////
  // Results
  ////////////////////////////////////////////////////////////

  BurstPeriodStat wrPeriod (                    // Write direction gaps
    .SysClk   (SysClk),
    .Reset_N  (Reset_N),
    .StatiClr (StatiClr),
    .EndEvt   (WrEndEvt),
    .PeriMin  (WrPeriMin),
    .PeriMax  (WrPeriMax)
  );

  BurstPeriodStat rdPeriod (                    // Read direction gaps
    .SysClk   (SysClk),
    .Reset_N  (Reset_N),
    .StatiClr (StatiClr),
    .EndEvt   (RdEndEvt),
    .PeriMin  (RdPeriMin),
    .PeriMax  (RdPeriMax)
  );

  IdleErrMonitor health0 (
    .SysClk    (SysClk),
    .Reset_N   (Reset_N),
    .StatiClr  (StatiClr),
    .BusActive (BusActive),
    .TestErr   (TestErr),
    .ErrCnt    (ErrCnt),
    .TimeOut   (TimeOut)
  );

endmodule

`default_nettype wire

//--- source/IdleErrMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module IdleErrMonitor
(
  input  wire logic           SysClk,     // System clock
  input  wire logic           Reset_N,    // Async reset, active low
  input  wire logic           StatiClr,   // Statistics clear
  input  wire logic           BusActive,  // Bus activity this cycle
  input  wire logic           TestErr,    // Read data compare failed
  output DdrStatPkg::ErrCnt_t ErrCnt,     // Test errors seen
  output logic                TimeOut     // One pulse per idle stretch
);

  import DdrStatPkg::*;

  ////////////////////////////////////////////////////////////
  // Idle watchdog
  ////////////////////////////////////////////////////////////

  logic [TimeoutW-1:0] IdleCnt;                 // Cycles left before timeout

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      IdleCnt <= TimeoutLoad;
      TimeOut <= 1'b0;
    end
    else
    begin
      if (BusActive)
        IdleCnt <= TimeoutLoad;                 // Activity rearms
      else if (|IdleCnt)
        IdleCnt <= IdleCnt - TimeoutW'(1);      // Holds at zero
      TimeOut <= (IdleCnt == TimeoutW'(1));     // Fires once on the way down
    end
  end

  ////////////////////////////////////////////////////////////
  // Test error counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
      ErrCnt <= '0;
    else if (StatiClr)
      ErrCnt <= '0;
    else if (TestErr && !(&ErrCnt))
      ErrCnt <= ErrCnt + ErrCnt_t'(1);          // Saturates at all ones
  end

endmodule

`default_nettype wire

//--- source/BurstPeriodStat.sv
`timescale 1ns/1ps
`default_nettype none

module BurstPeriodStat
(
  input  wire logic           SysClk,    // System clock
  input  wire logic           Reset_N,   // Async reset, active low
  input  wire logic           StatiClr,  // Statistics clear
  input  wire logic           EndEvt,    // Burst end pulse
  output DdrStatPkg::Period_t PeriMin,   // Smallest gap seen
  output DdrStatPkg::Period_t PeriMax    // Largest gap seen
);

  import DdrStatPkg::*;

  ////////////////////////////////////////////////////////////
  // Gap measurement
  ////////////////////////////////////////////////////////////

  Period_t GapCnt;                              // Cycles since last end
  logic    Started;                             // A previous end is known
  Period_t GapReg;                              // Captured gap
  logic    GapVld;                              // GapReg holds a fresh gap

  // Counter restarts at 1 so a gap equals the distance between end pulses
  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      GapCnt  <= '0;
      Started <= 1'b0;
      GapVld  <= 1'b0;
    end
    else if (StatiClr)
    begin
      GapCnt  <= '0;
      Started <= 1'b0;                          // Forget the last end time
      GapVld  <= 1'b0;
    end
    else
    begin
      if (EndEvt)
        GapCnt <= Period_t'(1);
      else if (!(&GapCnt))
        GapCnt <= GapCnt + Period_t'(1);        // Saturates at 1023
      if (EndEvt)
        Started <= 1'b1;
      GapVld <= EndEvt & Started;               // First end records nothing
    end
  end

  always_ff @(posedge SysClk)
  begin
    if (EndEvt)
      GapReg <= GapCnt;
  end

  ////////////////////////////////////////////////////////////
  // Running min and max
  ////////////////////////////////////////////////////////////

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      PeriMin <= PeriodMinInit;
      PeriMax <= '0;
    end
    else if (StatiClr)
    begin
      PeriMin <= PeriodMinInit;
      PeriMax <= '0;
    end
    else if (GapVld)
    begin
      if (GapReg < PeriMin)
        PeriMin <= GapReg;                      // New shortest gap
      if (GapReg > PeriMax)
        PeriMax <= GapReg;                      // New longest gap
    end
  end

endmodule

`default_nettype wire

//--- source/BusOccupancy.sv
`timescale 1ns/1ps
`default_nettype none

module BusOccupancy
(
  input  wire logic           SysClk,     // System clock
  input  wire logic           Reset_N,    // Async reset, active low
  input  wire logic           StatiClr,   // Statistics clear
  input  wire logic           WrAddrEvt,  // Write burst start
  input  wire logic           RdAddrEvt,  // Read burst start
  input  wire logic           WrBeatEvt,  // Write beat
  input  wire logic           RdBeatEvt,  // Read beat
  input  wire logic           WrEndEvt,   // Write burst end
  input  wire logic           RdEndEvt,   // Read burst end
  output logic                BusActive,  // Any address or beat this cycle
  output DdrStatPkg::CycCnt_t OpTotCyc,   // Cycles with a burst outstanding
  output DdrStatPkg::CycCnt_t OpActCyc    // Data beats transferred
);

  import DdrStatPkg::*;

  // Saturating up/down step, no change when start and end coincide
  function automatic BurstCnt_t NextBurstCnt(input BurstCnt_t Cnt,
                                             input logic      Up,
                                             input logic      Down);
    BurstCnt_t Next;
    Next = Cnt;
    if (Up && !Down && !(&Cnt))
      Next = Cnt + BurstCnt_t'(1);              // Stops at all ones
    else if (Down && !Up && (|Cnt))
      Next = Cnt - BurstCnt_t'(1);              // Stops at zero
    return Next;
  endfunction

  ////////////////////////////////////////////////////////////
  // Outstanding bursts and busy flag
  ////////////////////////////////////////////////////////////

  BurstCnt_t WrBurstCnt;                        // Write bursts in flight
  BurstCnt_t RdBurstCnt;                        // Read bursts in flight
  logic      OpBusy;                            // Either direction in flight

  assign BusActive = WrAddrEvt | RdAddrEvt | WrBeatEvt | RdBeatEvt;

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      WrBurstCnt <= '0;
      RdBurstCnt <= '0;
      OpBusy     <= 1'b0;
    end
    else
    begin
      WrBurstCnt <= NextBurstCnt(WrBurstCnt, WrAddrEvt, WrEndEvt);
      RdBurstCnt <= NextBurstCnt(RdBurstCnt, RdAddrEvt, RdEndEvt);
      OpBusy     <= (|WrBurstCnt) | (|RdBurstCnt); // Lags the counts by one
    end
  end

  ////////////////////////////////////////////////////////////
  // Busy and beat accumulators
  ////////////////////////////////////////////////////////////

  BeatCnt_t BeatCnt;                            // Beats of the previous cycle

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
      BeatCnt <= '0;
    else
      BeatCnt <= BeatCnt_t'(WrBeatEvt) + BeatCnt_t'(RdBeatEvt);
  end

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      OpTotCyc <= '0;
      OpActCyc <= '0;
    end
    else if (StatiClr)
    begin
      OpTotCyc <= '0;
      OpActCyc <= '0;
    end
    else
    begin
      if (OpBusy)
        OpTotCyc <= OpTotCyc + CycCnt_t'(1);    // One busy cycle
      OpActCyc <= OpActCyc + CycCnt_t'(BeatCnt); // 0, 1 or 2 beats
    end
  end

endmodule

`default_nettype wire

//--- source/AxiEventDecode.sv
`timescale 1ns/1ps
`default_nettype none

module AxiEventDecode
(
  input  wire logic SysClk,     // System clock
  input  wire logic Reset_N,    // Async reset, active low
  input  wire logic avalid,     // Address valid
  input  wire logic aready,     // Address ready
  input  wire logic atype,      // Burst type, 1 write, 0 read
  input  wire logic wvalid,     // Write data valid
  input  wire logic wready,     // Write data ready
  input  wire logic wlast,      // Last write beat
  input  wire logic rvalid,     // Read data valid
  input  wire logic rready,     // Read data ready
  input  wire logic rlast,      // Last read beat
  output logic      WrAddrEvt,  // Write address accepted
  output logic      RdAddrEvt,  // Read address accepted
  output logic      WrBeatEvt,  // Write beat transferred
  output logic      RdBeatEvt,  // Read beat transferred
  output logic      WrEndEvt,   // Write burst finished
  output logic      RdEndEvt    // Read burst finished
);

  ////////////////////////////////////////////////////////////
  // Input register stage
  ////////////////////////////////////////////////////////////

  logic RegAvalid, RegAready, RegAtype;         // Address channel copy
  logic RegWvalid, RegWready, RegWlast;         // Write channel copy
  logic RegRvalid, RegRready, RegRlast;         // Read channel copy

  // Bus signals sampled once, decode works on these only
  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      {RegAvalid, RegAready, RegAtype} <= 3'b000;
      {RegWvalid, RegWready, RegWlast} <= 3'b000;
      {RegRvalid, RegRready, RegRlast} <= 3'b000;
    end
    else
    begin
      {RegAvalid, RegAready, RegAtype} <= {avalid, aready, atype};
      {RegWvalid, RegWready, RegWlast} <= {wvalid, wready, wlast};
      {RegRvalid, RegRready, RegRlast} <= {rvalid, rready, rlast};
    end
  end

  ////////////////////////////////////////////////////////////
  // Event register stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge SysClk or negedge Reset_N)
  begin
    if (!Reset_N)
    begin
      WrAddrEvt <= 1'b0;
      RdAddrEvt <= 1'b0;
      WrBeatEvt <= 1'b0;
      RdBeatEvt <= 1'b0;
      WrEndEvt  <= 1'b0;
      RdEndEvt  <= 1'b0;
    end
    else
    begin
      WrAddrEvt <= RegAvalid & RegAready &  RegAtype;  // Write burst starts
      RdAddrEvt <= RegAvalid & RegAready & ~RegAtype;  // Read burst starts
      WrBeatEvt <= RegWvalid & RegWready;              // Any write beat
      RdBeatEvt <= RegRvalid & RegRready;              // Any read beat
      WrEndEvt  <= RegWvalid & RegWready & RegWlast;   // Closing write beat
      RdEndEvt  <= RegRvalid & RegRready & RegRlast;   // Closing read beat
    end
  end

endmodule

`default_nettype wire

//--- source/DdrStatPkg.sv
`default_nettype none

package DdrStatPkg;

  ////////////////////////////////////////////////////////////
  // Cycle statistics
  ////////////////////////////////////////////////////////////

  localparam int CountW = 48;                   // Total and actual cycle counters
  typedef logic [CountW-1:0] CycCnt_t;          // Busy or beat cycle count

  localparam int ErrW = 24;                     // Test error counter width
  typedef logic [ErrW-1:0] ErrCnt_t;            // Saturates at all ones

  // Beats seen in one cycle, write plus read, 0 to 2
  typedef logic [1:0] BeatCnt_t;

  ////////////////////////////////////////////////////////////
  // Burst bookkeeping
  ////////////////////////////////////////////////////////////

  localparam int BurstCntW = 8;                 // Outstanding bursts per direction
  typedef logic [BurstCntW-1:0] BurstCnt_t;     // Saturating up/down count

  localparam int PeriodW = 10;                  // Gap between burst ends
  typedef logic [PeriodW-1:0] Period_t;         // Cycles, saturates at 1023

  localparam Period_t PeriodMinInit = '1;       // Min register start value, 1023

  ////////////////////////////////////////////////////////////
  // Idle watchdog
  ////////////////////////////////////////////////////////////

  localparam int TimeoutW = 8;                  // Idle down-counter width
  localparam logic [TimeoutW-1:0] TimeoutLoad = 8'd255; // Reload on activity

endpackage

`default_nettype wire
